//--- Makefile
# Verilator lint and simulation of the up-sampling accelerator

VERILATOR  ?= verilator
TOP        ?= upsample_tb
SIM_F      ?= sim.f
OBJ_DIR    ?= obj_dir
PASS_MSG   ?= No errors
LINT_FLAGS ?= --lint-only --timing -Wall
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(SIM_F)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(SIM_F) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- sim.f
+incdir+verilog
verilog/axi_lite_pkg.sv
verilog/upsample_pkg.sv
verilog/sample_if.sv
verilog/config_register_file.sv
verilog/upsample_control.sv
verilog/sample_fetch.sv
verilog/sample_interp.sv
verilog/upsample_top.sv
testbench/upsample_sva.sv
testbench/upsample_tb.sv

//--- testbench/upsample_sva.sv
`default_nettype none
`include "upsample_params.svh"

module upsample_sva (
	input logic                   clk,
	input logic                   rst_n,
	input logic                   awready,
	input logic                   bvalid,
	input logic                   bready,
	input logic                   rvalid,
	input logic                   rready,
	input logic [`AXI_DATA_W-1:0] rdata,
	input logic                   mem_rd_en,
	input logic                   mem_wr_en,
	input logic                   interrupt
);
	timeunit 1ns;
	timeprecision 1ps;

	// Set by any destination write, cleared once the interrupt is up
	logic seen_wr;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			seen_wr <= 1'b0;
		end else if (mem_wr_en) begin
			seen_wr <= 1'b1;
		end else if (interrupt) begin
			seen_wr <= 1'b0;
		end
	end

	// B response held until taken
	a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
		bvalid && !bready |=> bvalid)
		else $error("bvalid dropped before bready");

	// R response and its data held until taken
	a_rdata_hold: assert property (@(posedge clk) disable iff (!rst_n)
		rvalid && !rready |=> rvalid && $stable(rdata))
		else $error("rvalid or rdata changed before rready");

	// No new write address while a response is pending
	a_aw_blocked: assert property (@(posedge clk) disable iff (!rst_n)
		!(awready && bvalid))
		else $error("awready pulsed while bvalid was high");

	// Memory ports quiet in reset
	a_mem_reset: assert property (@(posedge clk)
		!rst_n |=> !mem_wr_en && !mem_rd_en)
		else $error("memory port active during reset");

	// Done only after real output
	a_irq_after_write: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(interrupt) |-> seen_wr)
		else $error("interrupt rose without a destination write");

endmodule

`default_nettype wire

//--- testbench/upsample_tb.sv
`default_nettype none
`include "upsample_params.svh"

module upsample_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import axi_lite_pkg::*;
	import upsample_pkg::*;

	localparam logic [`AXI_ADDR_W-1:0] ADDR_START = 8'h00;
	localparam logic [`AXI_ADDR_W-1:0] ADDR_END   = 8'h04;
	localparam logic [`AXI_ADDR_W-1:0] ADDR_SRC   = 8'h08;
	localparam logic [`AXI_ADDR_W-1:0] ADDR_DST   = 8'h0C;

	logic                   clk;
	logic                   rst_n;
	logic                   awvalid;
	logic                   awready;
	logic [`AXI_ADDR_W-1:0] awaddr;
	logic [PROT_W-1:0]      awprot;
	logic                   wvalid;
	logic                   wready;
	logic [`AXI_DATA_W-1:0] wdata;
	logic [STRB_W-1:0]      wstrb;
	logic                   bvalid;
	logic                   bready;
	resp_t                  bresp;
	logic                   arvalid;
	logic                   arready;
	logic [`AXI_ADDR_W-1:0] araddr;
	logic [PROT_W-1:0]      arprot;
	logic                   rvalid;
	logic                   rready;
	logic [`AXI_DATA_W-1:0] rdata;
	resp_t                  rresp;
	logic                   mem_rd_en;
	logic [`MEM_ADDR_W-1:0] mem_rd_addr;
	sample_t                mem_rd_data = '0;
	logic                   mem_wr_en;
	logic [`MEM_ADDR_W-1:0] mem_wr_addr;
	sample_t                mem_wr_data;
	logic                   interrupt;

	// Source and destination memory models and the test data image
	sample_t     mem [0:(1<<`MEM_ADDR_W)-1];
	sample_t     wmem [0:(1<<`MEM_ADDR_W)-1];
	logic [15:0] tdata [0:255];
	int          wr_count = 0;
	int          cycles = 0;
	int          cycle_limit = 0;
	logic [15:0] lfsr_state = 16'd3;

	upsample_top u_dut (.*);

	bind upsample_top upsample_sva u_sva (
		.clk       (clk),
		.rst_n     (rst_n),
		.awready   (awready),
		.bvalid    (bvalid),
		.bready    (bready),
		.rvalid    (rvalid),
		.rready    (rready),
		.rdata     (rdata),
		.mem_rd_en (mem_rd_en),
		.mem_wr_en (mem_wr_en),
		.interrupt (interrupt)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Read data valid in the cycle after the address is registered
	always @(negedge clk) begin
		mem_rd_data <= mem_rd_en ? mem[mem_rd_addr] : '0;
	end

	// Capture destination writes mid-cycle
	always @(negedge clk) begin
		if (rst_n && mem_wr_en) begin
			wmem[mem_wr_addr] <= mem_wr_data;
			wr_count          <= wr_count + 1;
		end
	end

	// Watchdog
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("Timeout: jobs not finished after %0d cycles", cycles);
			$display("Errors found");
			$fatal(1, "watchdog expired");
		end
	end

	// Galois LFSR with taps x^16+x^14+x^13+x^11+1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		lfsr_step = (s >> 1) ^ (s[0] ? 16'hB400 : 16'h0000);
	endfunction

	// Handshake delay of 0 to 3 cycles with one LFSR step per bit
	task automatic draw_delay(output int d);
		d = 0;
		repeat (2) begin
			lfsr_state = lfsr_step(lfsr_state);
			d = (d << 1) | int'(lfsr_state[0]);
		end
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
			$display("Errors found");
			$fatal(1, "first error");
		end
	endtask

	task automatic axi_write(input logic [`AXI_ADDR_W-1:0] addr,
		input logic [`AXI_DATA_W-1:0] data);
		int   d;
		logic aw_hs;
		logic w_hs;
		draw_delay(d);
		@(negedge clk);
		awaddr  = addr;
		awvalid = 1'b1;
		wdata   = data;
		wvalid  = 1'b1;
		// Outputs seen here hold through the next rising edge
		while (awvalid || wvalid) begin
			aw_hs = awvalid && awready;
			w_hs  = wvalid && wready;
			@(negedge clk);
			if (aw_hs) begin
				awvalid = 1'b0;
			end
			if (w_hs) begin
				wvalid = 1'b0;
			end
		end
		while (!bvalid) begin
			@(negedge clk);
		end
		repeat (d) @(negedge clk);
		check("bvalid", bvalid, 1);
		check("bresp", bresp, RESP_OKAY);
		bready = 1'b1;
		@(negedge clk);
		bready = 1'b0;
	endtask

	task automatic axi_read(input logic [`AXI_ADDR_W-1:0] addr,
		output logic [`AXI_DATA_W-1:0] data);
		int   d;
		logic ar_hs;
		draw_delay(d);
		@(negedge clk);
		araddr  = addr;
		arvalid = 1'b1;
		while (arvalid) begin
			ar_hs = arvalid && arready;
			@(negedge clk);
			if (ar_hs) begin
				arvalid = 1'b0;
			end
		end
		while (!rvalid) begin
			@(negedge clk);
		end
		repeat (d) @(negedge clk);
		check("rvalid", rvalid, 1);
		check("rresp", rresp, RESP_OKAY);
		data   = rdata;
		rready = 1'b1;
		@(negedge clk);
		rready = 1'b0;
	endtask

	// Readback of all four registers plus holes and a stray write
	task automatic reg_test();
		logic [`AXI_ADDR_W-1:0] addrs [4];
		logic [`AXI_DATA_W-1:0] vals [4];
		logic [`AXI_DATA_W-1:0] rd;
		addrs = '{ADDR_SRC, ADDR_DST, ADDR_START, ADDR_END};
		// Bit 0 clear in START and END so no job and no interrupt
		vals  = '{32'h0000_0A5C, 32'h1234_0F0F, 32'h00C3_5A5A, 32'h8000_0002};
		foreach (addrs[i]) begin
			axi_write(addrs[i], vals[i]);
			axi_read(addrs[i], rd);
			check($sformatf("rdata @0x%0h", addrs[i]), rd, vals[i]);
		end
		check("interrupt", interrupt, 0);
		axi_read(8'h10, rd);
		check("rdata @0x10", rd, 0);
		axi_read(8'hFC, rd);
		check("rdata @0xfc", rd, 0);
		// Index bits alias END but upper bits make it a hole
		axi_write(8'h24, 32'hFFFF_FFFF);
		axi_read(ADDR_END, rd);
		check("rdata @0x4", rd, vals[3]);
		axi_write(ADDR_END, 32'h0);
		axi_write(ADDR_START, 32'h0);
	endtask

	task automatic run_job(inout int p);
		logic [15:0]            src;
		logic [15:0]            dst;
		logic [15:0]            n;
		int                     wr_base;
		logic [`AXI_DATA_W-1:0] rd;
		src     = tdata[p];
		dst     = tdata[p+1];
		n       = tdata[p+2];
		wr_base = wr_count;
		axi_write(ADDR_SRC, {16'h0, src});
		axi_write(ADDR_DST, {16'h0, dst});
		axi_write(ADDR_START, {n, 16'h0001});
		if (n == 0) begin
			// Poll until the controller drops the start bit
			rd = '1;
			while (rd[START_BIT]) begin
				axi_read(ADDR_START, rd);
			end
			check("UPSTR", rd, 0);
			// Long enough for a wrongly started job to reach memory
			repeat (16) @(negedge clk);
			check("interrupt", interrupt, 0);
			check("write count", wr_count - wr_base, 0);
		end else begin
			while (!interrupt) begin
				@(negedge clk);
			end
			check("write count", wr_count - wr_base, 2 * int'(n));
			for (int k = 0; k < 2 * int'(n); k++) begin
				check($sformatf("mem_wr_data @0x%0h", dst + k),
					wmem[dst+k], tdata[p+3+k]);
			end
			axi_read(ADDR_END, rd);
			check("UPENDR", rd, 1);
			axi_read(ADDR_START, rd);
			check("UPSTR", rd, {n, 16'h0000});
			// Host acknowledge
			axi_write(ADDR_END, 32'h0);
			check("interrupt", interrupt, 0);
			axi_read(ADDR_END, rd);
			check("UPENDR", rd, 0);
		end
		p = p + 3 + 2 * int'(n);
	endtask

	initial begin
		int p;
		int len;
		int njobs;
		int total;
		int q;
		rst_n   = 1'b0;
		awvalid = 1'b0;
		awaddr  = '0;
		awprot  = '0;
		wvalid  = 1'b0;
		wdata   = '0;
		wstrb   = '1;
		bready  = 1'b0;
		arvalid = 1'b0;
		araddr  = '0;
		arprot  = '0;
		rready  = 1'b0;
		for (int a = 0; a < (1 << `MEM_ADDR_W); a++) begin
			mem[a]  = 16'h5A00 ^ 16'(a);
			wmem[a] = 16'hDEAD ^ 16'(a);
		end
		$readmemh("testbench/upsample_testdata.txt", tdata);
		// Source image first and job records after it
		len = int'(tdata[1]);
		for (int i = 0; i < len; i++) begin
			mem[tdata[0] + i] = tdata[2+i];
		end
		p     = 2 + len;
		njobs = int'(tdata[p]);
		p++;
		q     = p;
		total = 0;
		for (int j = 0; j < njobs; j++) begin
			total += int'(tdata[q+2]);
			q += 3 + 2 * int'(tdata[q+2]);
		end
		cycle_limit = 200 * njobs + 8 * total;
		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		reg_test();
		for (int j = 0; j < njobs; j++) begin
			run_job(p);
		end
		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- testbench/upsample_testdata.txt
// Image: base address, word count, then the source samples
// Jobs: job count, then per job src, dst, N and the 2N expected outputs
0010 0008
0010 0030 0025 FFFF FFFE 8000 0001 1234
0004
// Small ramp, last average carries into bit 15
0010 0100 0004
0010 0020 0030 002A 0025 8012 FFFF FFFF
// Full-scale pair sums
0014 0200 0003
FFFE BFFF 8000 4000 0001 0001
// Single sample gives two copies
0017 0300 0001
1234 1234
// Zero count, nothing written and no interrupt
0010 0380 0000

//--- verilog/axi_lite_pkg.sv
`default_nettype none
`include "upsample_params.svh"

package axi_lite_pkg;

	// Response code on B and R channels
	typedef logic [1:0] resp_t;

	// Only response this slave ever gives
	localparam resp_t RESP_OKAY = 2'b00;

	// Byte strobe and protection field widths
	localparam int STRB_W = `AXI_DATA_W / 8;
	localparam int PROT_W = 3;

endpackage

`default_nettype wire

//--- verilog/config_register_file.sv
`default_nettype none
`include "upsample_params.svh"

module config_register_file (
	input  logic                              clk,
	input  logic                              rst_n,
	// Write address channel
	input  logic                              awvalid,
	output logic                              awready,
	input  logic [`AXI_ADDR_W-1:0]            awaddr,
	input  logic [axi_lite_pkg::PROT_W-1:0]   awprot,
	// Write data channel
	input  logic                              wvalid,
	output logic                              wready,
	input  logic [`AXI_DATA_W-1:0]            wdata,
	input  logic [axi_lite_pkg::STRB_W-1:0]   wstrb,
	// Write response channel
	output logic                              bvalid,
	input  logic                              bready,
	output axi_lite_pkg::resp_t               bresp,
	// Read address channel
	input  logic                              arvalid,
	output logic                              arready,
	input  logic [`AXI_ADDR_W-1:0]            araddr,
	input  logic [axi_lite_pkg::PROT_W-1:0]   arprot,
	// Read data channel
	output logic                              rvalid,
	input  logic                              rready,
	output logic [`AXI_DATA_W-1:0]            rdata,
	output axi_lite_pkg::resp_t               rresp,
	// Logic-side write port
	input  logic                              ac_wrt,
	input  upsample_pkg::crf_index_t          ac_addr,
	input  logic [`AXI_DATA_W-1:0]            ac_data,
	output logic                              wbusy,
	// Register words
	output logic [`AXI_DATA_W-1:0]            reg_start,
	output logic [`AXI_DATA_W-1:0]            reg_end,
	output logic [`AXI_DATA_W-1:0]            reg_src,
	output logic [`AXI_DATA_W-1:0]            reg_dst,
	output logic                              interrupt
);
	import axi_lite_pkg::*;
	import upsample_pkg::*;

	logic                   wr_busy;
	crf_index_t             w_idx;
	logic                   w_mapped;
	logic                   ac_wren;
	logic                   axi_wren;
	logic                   wr_sel;
	crf_index_t             wr_idx;
	logic [`AXI_DATA_W-1:0] wr_data;
	logic                   rd_hs;
	crf_index_t             r_idx;
	logic                   r_mapped;
	logic [`AXI_DATA_W-1:0] rd_word;

	// Strobes and protection bits are accepted and ignored
	assign bresp     = RESP_OKAY;
	assign rresp     = RESP_OKAY;
	assign wbusy     = wr_busy;
	// Done flag is the interrupt line
	assign interrupt = reg_end[DONE_BIT];

	// Busy from AW handshake to B handshake
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_busy <= 1'b0;
		end else if (wr_busy) begin
			if (bvalid && bready) begin
				wr_busy <= 1'b0;
			end
		end else if (awvalid && awready) begin
			wr_busy <= 1'b1;
		end
	end

	// One-cycle AW accept while idle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			awready <= 1'b0;
		end else begin
			awready <= !wr_busy && awvalid && !awready;
		end
	end

	// Byte address bits 3:2 give the index, anything above is a hole
	always_ff @(posedge clk) begin
		if (awvalid && awready) begin
			w_idx    <= crf_index_t'(awaddr[`CRF_ADDR_W+1:2]);
			w_mapped <= ~|awaddr[`AXI_ADDR_W-1:`CRF_ADDR_W+2];
		end
	end

	// W accept once the address is held, never again until B is done
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wready <= 1'b0;
		end else begin
			wready <= wr_busy && wvalid && !wready && !bvalid;
		end
	end

	// Logic side only writes while no AXI write is open
	assign ac_wren  = ac_wrt & ~wr_busy;
	assign axi_wren = wvalid & wready;
	// Logic side wins a same-cycle clash
	assign wr_sel   = ac_wren | (axi_wren & w_mapped);
	assign wr_idx   = ac_wren ? ac_addr : w_idx;
	assign wr_data  = ac_wren ? ac_data : wdata;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			reg_start <= '0;
			reg_end   <= '0;
			reg_src   <= '0;
			reg_dst   <= '0;
		end else if (wr_sel) begin
			case (wr_idx)
				REG_START: reg_start <= wr_data;
				REG_END:   reg_end   <= wr_data;
				REG_SRC:   reg_src   <= wr_data;
				REG_DST:   reg_dst   <= wr_data;
			endcase
		end
	end

	// Response after the data beat, held until bready
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bvalid <= 1'b0;
		end else if (bvalid) begin
			if (bready) begin
				bvalid <= 1'b0;
			end
		end else if (axi_wren) begin
			bvalid <= 1'b1;
		end
	end

	// AR accept blocked while a read response is pending
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			arready <= 1'b0;
		end else begin
			arready <= arvalid && !arready && !rvalid;
		end
	end

	assign rd_hs    = arvalid & arready;
	assign r_idx    = crf_index_t'(araddr[`CRF_ADDR_W+1:2]);
	assign r_mapped = ~|araddr[`AXI_ADDR_W-1:`CRF_ADDR_W+2];

	// Read mux, holes read zero
	always_comb begin
		rd_word = '0;
		if (r_mapped) begin
			case (r_idx)
				REG_START: rd_word = reg_start;
				REG_END:   rd_word = reg_end;
				REG_SRC:   rd_word = reg_src;
				REG_DST:   rd_word = reg_dst;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rvalid <= 1'b0;
		end else if (rvalid) begin
			if (rready) begin
				rvalid <= 1'b0;
			end
		end else if (rd_hs) begin
			rvalid <= 1'b1;
		end
	end

	// Data only loads on AR handshake, so it holds while rvalid waits
	always_ff @(posedge clk) begin
		if (rd_hs) begin
			rdata <= rd_word;
		end
	end

endmodule

`default_nettype wire

//--- verilog/sample_fetch.sv
`default_nettype none
`include "upsample_params.svh"

module sample_fetch (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   job_start,
	input  logic [`AXI_DATA_W-1:0] reg_src,
	input  logic [`AXI_DATA_W-1:0] reg_start,
	output logic                   mem_rd_en,
	output logic [`MEM_ADDR_W-1:0] mem_rd_addr,
	input  upsample_pkg::sample_t  mem_rd_data,
	sample_if.src                  smp
);
	import upsample_pkg::*;

	logic [COUNT_MSB-COUNT_LSB:0] req_count;
	logic [`MEM_ADDR_W-1:0]       job_count;
	logic [`MEM_ADDR_W-1:0]       left;
	logic                         issue;
	logic                         rd_first;
	logic                         rd_last;

	// Count saturates at what the memory can hold
	assign req_count = reg_start[COUNT_MSB:COUNT_LSB];
	assign job_count = (req_count > `MAX_COUNT) ?
		`MEM_ADDR_W'(`MAX_COUNT) : req_count[`MEM_ADDR_W-1:0];

	// Next read after a one-cycle gap
	assign issue = !job_start && !mem_rd_en && (left != '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem_rd_en <= 1'b0;
			left      <= '0;
			smp.valid <= 1'b0;
		end else begin
			// Data returns one cycle after the read
			smp.valid <= mem_rd_en;
			if (job_start) begin
				mem_rd_en <= 1'b1;
				left      <= job_count - 1'b1;
			end else if (issue) begin
				mem_rd_en <= 1'b1;
				left      <= left - 1'b1;
			end else begin
				mem_rd_en <= 1'b0;
			end
		end
	end

	// Tags ride along with the read in flight
	always_ff @(posedge clk) begin
		if (job_start) begin
			mem_rd_addr <= reg_src[`MEM_ADDR_W-1:0];
			rd_first    <= 1'b1;
			rd_last     <= (job_count == `MEM_ADDR_W'(1));
		end else if (issue) begin
			mem_rd_addr <= mem_rd_addr + 1'b1;
			rd_first    <= 1'b0;
			rd_last     <= (left == `MEM_ADDR_W'(1));
		end
		if (mem_rd_en) begin
			smp.data  <= mem_rd_data;
			smp.first <= rd_first;
			smp.last  <= rd_last;
		end
	end

endmodule

`default_nettype wire

//--- verilog/sample_if.sv
`default_nettype none
`include "upsample_params.svh"

interface sample_if;
	import upsample_pkg::*;

	// Single-cycle strobe per source sample
	logic    valid;
	sample_t data;
	// s[0] and s[N-1] markers
	logic    first;
	logic    last;

	// Fetch side
	modport src (output valid, data, first, last);
	// Interpolation side
	modport dst (input valid, data, first, last);

endinterface

`default_nettype wire

//--- verilog/sample_interp.sv
`default_nettype none
`include "upsample_params.svh"

module sample_interp (
	input  logic                   clk,
	input  logic                   rst_n,
	sample_if.dst                  smp,
	input  logic [`AXI_DATA_W-1:0] reg_dst,
	output logic                   mem_wr_en,
	output logic [`MEM_ADDR_W-1:0] mem_wr_addr,
	output upsample_pkg::sample_t  mem_wr_data,
	output logic                   job_done
);
	import upsample_pkg::*;

	sample_t                prev;
	logic [`SAMPLE_W:0]     pair_sum;
	sample_t                avg;
	// Stage two output pair
	logic                   pvalid;
	logic                   plast;
	sample_t                pa;
	sample_t                pb;
	logic [1:0]             tail;
	// Stage three second word
	logic                   second;
	logic                   hold_last;
	sample_t                hold_b;
	logic [`MEM_ADDR_W-1:0] dst_ptr;

	// Rounded down mean, carry kept
	assign pair_sum = {1'b0, prev} + {1'b0, smp.data};
	assign avg      = pair_sum[`SAMPLE_W:1];

	// Stage two control
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pvalid <= 1'b0;
			plast  <= 1'b0;
			tail   <= 2'b00;
		end else begin
			// s[0] only primes prev
			pvalid <= (smp.valid && !smp.first) || tail[1];
			plast  <= tail[1] && !smp.valid;
			// Final copies wait two cycles for the pair ahead
			tail   <= {tail[0], smp.valid && smp.last};
		end
	end

	always_ff @(posedge clk) begin
		if (smp.valid) begin
			prev <= smp.data;
			pa   <= prev;
			pb   <= avg;
		end else if (tail[1]) begin
			pa <= prev;
			pb <= prev;
		end
	end

	// Stage three control, one word per cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem_wr_en <= 1'b0;
			second    <= 1'b0;
			hold_last <= 1'b0;
			job_done  <= 1'b0;
		end else if (pvalid) begin
			mem_wr_en <= 1'b1;
			second    <= 1'b1;
			hold_last <= plast;
			job_done  <= 1'b0;
		end else if (second) begin
			mem_wr_en <= 1'b1;
			second    <= 1'b0;
			// Done strobe aligned with the last word
			job_done  <= hold_last;
		end else begin
			mem_wr_en <= 1'b0;
			job_done  <= 1'b0;
		end
	end

	// Destination pointer loads on s[0], steps by two per pair
	always_ff @(posedge clk) begin
		if (smp.valid && smp.first) begin
			dst_ptr <= reg_dst[`MEM_ADDR_W-1:0];
		end else if (pvalid) begin
			dst_ptr <= dst_ptr + `MEM_ADDR_W'(2);
		end
		if (pvalid) begin
			mem_wr_addr <= dst_ptr;
			mem_wr_data <= pa;
			hold_b      <= pb;
		end else if (second) begin
			mem_wr_addr <= mem_wr_addr + 1'b1;
			mem_wr_data <= hold_b;
		end
	end

endmodule

`default_nettype wire

//--- verilog/upsample_control.sv
`default_nettype none
`include "upsample_params.svh"

module upsample_control (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic [`AXI_DATA_W-1:0]   reg_start,
	input  logic [`AXI_DATA_W-1:0]   reg_end,
	output logic                     ac_wrt,
	output upsample_pkg::crf_index_t ac_addr,
	output logic [`AXI_DATA_W-1:0]   ac_data,
	input  logic                     wbusy,
	output logic                     job_start,
	input  logic                     job_done
);
	import upsample_pkg::*;

	ctrl_state_t state;
	ctrl_state_t state_nxt;
	logic        count_ok;

	// Zero count jobs are dropped
	assign count_ok = |reg_start[COUNT_MSB:COUNT_LSB];

	// Write request held until the register file is free
	assign ac_wrt    = (state == CLEAR_START) || (state == SET_DONE);
	// Start pulse coincides with the accepted clear
	assign job_start = (state == CLEAR_START) && !wbusy && count_ok;

	// Clear start bit, keep count; or set done bit
	always_comb begin
		ac_addr            = REG_START;
		ac_data            = reg_start;
		ac_data[START_BIT] = 1'b0;
		if (state == SET_DONE) begin
			ac_addr           = REG_END;
			ac_data           = reg_end;
			ac_data[DONE_BIT] = 1'b1;
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (reg_start[START_BIT]) begin
					state_nxt = CLEAR_START;
				end
			end
			CLEAR_START: begin
				if (!wbusy) begin
					state_nxt = count_ok ? RUN : IDLE;
				end
			end
			// Wait for the final write
			RUN: begin
				if (job_done) begin
					state_nxt = SET_DONE;
				end
			end
			SET_DONE: begin
				if (!wbusy) begin
					state_nxt = IDLE;
				end
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
		end else begin
			state <= state_nxt;
		end
	end

endmodule

`default_nettype wire

//--- verilog/upsample_params.svh
`ifndef UPSAMPLE_PARAMS_SVH
`define UPSAMPLE_PARAMS_SVH

// AXI4-Lite bus widths
`define AXI_DATA_W 32
`define AXI_ADDR_W 8

// Sample word and sample memory address
`define SAMPLE_W 16
`define MEM_ADDR_W 12

// Register index, four words
`define CRF_ADDR_W 2

// Largest sample count one job may carry
`define MAX_COUNT 4095

`endif

//--- verilog/upsample_pkg.sv
`default_nettype none
`include "upsample_params.svh"

package upsample_pkg;

	// Word index of the four config registers
	typedef enum logic [`CRF_ADDR_W-1:0] {
		REG_START = 2'd0,
		REG_END   = 2'd1,
		REG_SRC   = 2'd2,
		REG_DST   = 2'd3
	} crf_index_t;

	// One audio sample
	typedef logic [`SAMPLE_W-1:0] sample_t;

	// Job sequencer states
	typedef enum logic [1:0] {IDLE, CLEAR_START, RUN, SET_DONE} ctrl_state_t;

	// Field positions inside UPSTR and UPENDR
	localparam int START_BIT = 0;
	localparam int COUNT_LSB = 16;
	localparam int COUNT_MSB = 31;
	localparam int DONE_BIT  = 0;

endpackage

`default_nettype wire

//--- verilog/upsample_top.sv
`default_nettype none
`include "upsample_params.svh"

module upsample_top (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            awvalid,
	output logic                            awready,
	input  logic [`AXI_ADDR_W-1:0]          awaddr,
	input  logic [axi_lite_pkg::PROT_W-1:0] awprot,
	input  logic                            wvalid,
	output logic                            wready,
	input  logic [`AXI_DATA_W-1:0]          wdata,
	input  logic [axi_lite_pkg::STRB_W-1:0] wstrb,
	output logic                            bvalid,
	input  logic                            bready,
	output axi_lite_pkg::resp_t             bresp,
	input  logic                            arvalid,
	output logic                            arready,
	input  logic [`AXI_ADDR_W-1:0]          araddr,
	input  logic [axi_lite_pkg::PROT_W-1:0] arprot,
	output logic                            rvalid,
	input  logic                            rready,
	output logic [`AXI_DATA_W-1:0]          rdata,
	output axi_lite_pkg::resp_t             rresp,
	// Sample memory ports
	output logic                            mem_rd_en,
	output logic [`MEM_ADDR_W-1:0]          mem_rd_addr,
	input  upsample_pkg::sample_t           mem_rd_data,
	output logic                            mem_wr_en,
	output logic [`MEM_ADDR_W-1:0]          mem_wr_addr,
	output upsample_pkg::sample_t           mem_wr_data,
	output logic                            interrupt
);
	import upsample_pkg::*;

	logic [`AXI_DATA_W-1:0] reg_start;
	logic [`AXI_DATA_W-1:0] reg_end;
	logic [`AXI_DATA_W-1:0] reg_src;
	logic [`AXI_DATA_W-1:0] reg_dst;
	logic                   ac_wrt;
	crf_index_t             ac_addr;
	logic [`AXI_DATA_W-1:0] ac_data;
	logic                   wbusy;
	logic                   job_start;
	logic                   job_done;

	// Source sample stream, fetch to interpolation
	sample_if u_smp ();

	config_register_file u_crf (
		.clk       (clk),
		.rst_n     (rst_n),
		.awvalid   (awvalid),
		.awready   (awready),
		.awaddr    (awaddr),
		.awprot    (awprot),
		.wvalid    (wvalid),
		.wready    (wready),
		.wdata     (wdata),
		.wstrb     (wstrb),
		.bvalid    (bvalid),
		.bready    (bready),
		.bresp     (bresp),
		.arvalid   (arvalid),
		.arready   (arready),
		.araddr    (araddr),
		.arprot    (arprot),
		.rvalid    (rvalid),
		.rready    (rready),
		.rdata     (rdata),
		.rresp     (rresp),
		.ac_wrt    (ac_wrt),
		.ac_addr   (ac_addr),
		.ac_data   (ac_data),
		.wbusy     (wbusy),
		.reg_start (reg_start),
		.reg_end   (reg_end),
		.reg_src   (reg_src),
		.reg_dst   (reg_dst),
		.interrupt (interrupt)
	);

	upsample_control u_ctrl (
		.clk       (clk),
		.rst_n     (rst_n),
		.reg_start (reg_start),
		.reg_end   (reg_end),
		.ac_wrt    (ac_wrt),
		.ac_addr   (ac_addr),
		.ac_data   (ac_data),
		.wbusy     (wbusy),
		.job_start (job_start),
		.job_done  (job_done)
	);

	sample_fetch u_fetch (
		.clk         (clk),
		.rst_n       (rst_n),
		.job_start   (job_start),
		.reg_src     (reg_src),
		.reg_start   (reg_start),
		.mem_rd_en   (mem_rd_en),
		.mem_rd_addr (mem_rd_addr),
		.mem_rd_data (mem_rd_data),
		.smp         (u_smp.src)
	);

	sample_interp u_interp (
		.clk         (clk),
		.rst_n       (rst_n),
		.smp         (u_smp.dst),
		.reg_dst     (reg_dst),
		.mem_wr_en   (mem_wr_en),
		.mem_wr_addr (mem_wr_addr),
		.mem_wr_data (mem_wr_data),
		.job_done    (job_done)
	);

endmodule

`default_nettype wire
